/* include/ntt_defines.svh */
/* NTT forward stage parameters
   widths, Solinas modulus, butterflies per beat and batch length */

`ifndef NTT_DEFINES_SVH
`define NTT_DEFINES_SVH

// ==============================
// arithmetic
// ==============================
// coefficient width
`define NTT_OP_W 32
// 2^32 - 2^17 - 2^13 + 1
`define NTT_MOD 32'hFFFD_E001

// ==============================
// beat geometry
// ==============================
// radix-2 butterflies per beat
`define NTT_PSI 2
// butterfly radix
`define NTT_R 2
// bootstrapping key factors per coefficient
`define NTT_K_P1 2

// ==============================
// batch framing
// ==============================
`define NTT_PBS_ID_W 4
// beats per batch
`define NTT_BATCH_BEATS 4
// must hold NTT_BATCH_BEATS-1
`define NTT_BEAT_CNT_W 2

`endif

/* design/ntt_arith_pkg.sv */
/* NTT arithmetic package
   coefficient and beat word types, modular add, sub, reduce and multiply */

`default_nettype none

`include "ntt_defines.svh"

package ntt_arith_pkg;

  typedef logic [`NTT_OP_W-1:0] coef_t;
  // one beat of butterfly inputs or outputs, [butterfly][leg]
  typedef coef_t [`NTT_PSI-1:0][`NTT_R-1:0] bfly_word_t;
  // one twiddle per butterfly
  typedef coef_t [`NTT_PSI-1:0] twd_word_t;
  // key factors for every coefficient, [butterfly][leg][factor]
  typedef coef_t [`NTT_PSI-1:0][`NTT_R-1:0][`NTT_K_P1-1:0] bsk_word_t;
  typedef coef_t [`NTT_PSI-1:0][`NTT_R-1:0][`NTT_K_P1-1:0] pp_word_t;

  // inputs already below the modulus
  function automatic coef_t mod_add(input coef_t a, input coef_t b);
    logic [`NTT_OP_W:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= `NTT_MOD) begin
      s = s - `NTT_MOD;
    end
    return coef_t'(s);
  endfunction

  // wraps mod 2^32, result lands below the modulus
  function automatic coef_t mod_sub(input coef_t a, input coef_t b);
    coef_t d;
    d = a - b;
    if (a < b) begin
      d = d + `NTT_MOD;
    end
    return d;
  endfunction

  // Solinas fold, 2^32 == 2^17 + 2^13 - 1 mod p
  // three folds shrink 64 bits to under 2^32 + 2^24
  function automatic coef_t mod_red(input logic [2*`NTT_OP_W-1:0] x);
    logic [50:0] t1;
    logic [37:0] t2;
    logic [32:0] t3;
    t1 = 51'(x[31:0]) + (51'(x[63:32]) << 17) + (51'(x[63:32]) << 13) - 51'(x[63:32]);
    t2 = 38'(t1[31:0]) + (38'(t1[50:32]) << 17) + (38'(t1[50:32]) << 13)
         - 38'(t1[50:32]);
    t3 = 33'(t2[31:0]) + (33'(t2[37:32]) << 17) + (33'(t2[37:32]) << 13)
         - 33'(t2[37:32]);
    // one conditional subtract is enough at this size
    if (t3 >= `NTT_MOD) begin
      t3 = t3 - `NTT_MOD;
    end
    return coef_t'(t3);
  endfunction

  function automatic coef_t mod_mul(input coef_t a, input coef_t b);
    logic [2*`NTT_OP_W-1:0] p;
    p = (2*`NTT_OP_W)'(a) * (2*`NTT_OP_W)'(b);
    return mod_red(p);
  endfunction

endpackage

`default_nettype wire

/* design/ntt_ctrl_pkg.sv */
/* NTT stream control package
   beat control struct, sticky error word and batch state encoding */

`default_nettype none

`include "ntt_defines.svh"

package ntt_ctrl_pkg;

  // ==============================
  // stream control
  // ==============================
  // avail-style stream, no ready
  typedef struct packed {
    logic                     avail;
    // start and end of batch
    logic                     sob;
    logic                     eob;
    // batch tag, travels with the data
    logic [`NTT_PBS_ID_W-1:0] pbs_id;
  } stream_ctrl_t;

  // ==============================
  // errors
  // ==============================
  // all bits sticky until reset
  typedef struct packed {
    // accepted beat without twiddle
    logic twd_miss;
    // accepted beat without key factors
    logic bsk_miss;
    // batch length mismatch
    logic framing;
  } ntt_error_t;

  // ==============================
  // batch FSM
  // ==============================
  typedef enum logic {
    IDLE     = 1'b0,
    IN_BATCH = 1'b1
  } batch_state_e;

endpackage

`default_nettype wire

/* design/ntt_batch_fsm.sv */
/* NTT batch framing FSM
   accepts beats only inside a sob..eob frame, flags length mismatches */

`timescale 1ns/100ps
`default_nettype none

module ntt_batch_fsm (
  input  logic                       clk,
  input  logic                       rst_n,
  input  ntt_ctrl_pkg::stream_ctrl_t in_ctrl,
  // counter says this is the terminal beat
  input  logic                       last_beat,
  output logic                       accept,
  output logic                       framing_err
);

  ntt_ctrl_pkg::batch_state_e state;
  ntt_ctrl_pkg::batch_state_e state_nxt;

  // a beat is taken inside a frame or when it opens one
  // beats outside a frame are dropped
  assign accept = in_ctrl.avail & ((state == ntt_ctrl_pkg::IN_BATCH) | in_ctrl.sob);

  always_comb begin
    state_nxt = state;
    if (accept) begin
      // eob closes the batch, also for a sob+eob single beat
      if (in_ctrl.eob) begin
        state_nxt = ntt_ctrl_pkg::IDLE;
      end else begin
        state_nxt = ntt_ctrl_pkg::IN_BATCH;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ntt_ctrl_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // eob must coincide with the terminal count
  // early eob or missing eob both count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      framing_err <= 1'b0;
    end else if (accept && (in_ctrl.eob != last_beat)) begin
      framing_err <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/ntt_beat_counter.sv */
/* NTT beat counter
   counts accepted beats of the current batch and flags the terminal one */

`timescale 1ns/100ps
`default_nettype none

`include "ntt_defines.svh"

module ntt_beat_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic accept,
  // eob of the beat being accepted
  input  logic eob,
  output logic last_beat
);

  logic [`NTT_BEAT_CNT_W-1:0] beat_cnt;

  // position of the beat on the input right now
  assign last_beat = (beat_cnt == `NTT_BEAT_CNT_W'(`NTT_BATCH_BEATS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
    end else if (accept) begin
      // restart at every accepted eob, whatever the length was
      if (eob) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/ntt_clbu.sv */
/* NTT cluster butterfly unit
   PSI radix-2 DIT butterflies a + w.b and a - w.b mod p, 3-cycle pipeline */

`timescale 1ns/100ps
`default_nettype none

`include "ntt_defines.svh"

module ntt_clbu (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       accept,
  input  ntt_arith_pkg::bfly_word_t  in_data,
  input  ntt_ctrl_pkg::stream_ctrl_t in_ctrl,
  input  ntt_arith_pkg::twd_word_t   twd,
  input  logic                       twd_vld,
  output ntt_arith_pkg::bfly_word_t  out_data,
  output ntt_ctrl_pkg::stream_ctrl_t out_ctrl,
  output logic                       twd_miss
);

  // stage 1, captured operands
  ntt_arith_pkg::bfly_word_t              s1_data;
  ntt_arith_pkg::twd_word_t               s1_twd;
  ntt_ctrl_pkg::stream_ctrl_t             s1_ctrl;
  // stage 2, a and reduced w.b per butterfly
  ntt_arith_pkg::coef_t [`NTT_PSI-1:0]    s2_a;
  ntt_arith_pkg::coef_t [`NTT_PSI-1:0]    s2_wb;
  ntt_ctrl_pkg::stream_ctrl_t             s2_ctrl;

  // ==============================
  // control pipe
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_ctrl  <= '0;
      s2_ctrl  <= '0;
      out_ctrl <= '0;
    end else begin
      s1_ctrl       <= in_ctrl;
      // only accepted beats carry on downstream
      s1_ctrl.avail <= accept;
      s2_ctrl       <= s1_ctrl;
      out_ctrl      <= s2_ctrl;
    end
  end

  // ==============================
  // data pipe
  // ==============================
  always_ff @(posedge clk) begin
    // operands held while nothing is accepted
    if (accept) begin
      s1_data <= in_data;
      s1_twd  <= twd;
    end
    for (int i = 0; i < `NTT_PSI; i++) begin
      // leg 0 is a, leg 1 is b
      s2_a[i]  <= s1_data[i][0];
      s2_wb[i] <= ntt_arith_pkg::mod_mul(s1_data[i][1], s1_twd[i]);
    end
    for (int i = 0; i < `NTT_PSI; i++) begin
      out_data[i][0] <= ntt_arith_pkg::mod_add(s2_a[i], s2_wb[i]);
      out_data[i][1] <= ntt_arith_pkg::mod_sub(s2_a[i], s2_wb[i]);
    end
  end

  // twiddle must come with every accepted beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      twd_miss <= 1'b0;
    end else if (accept && !twd_vld) begin
      twd_miss <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/ntt_post_process.sv */
/* NTT post process
   multiplies every butterfly output by each key factor mod p, 2-cycle pipe */

`timescale 1ns/100ps
`default_nettype none

`include "ntt_defines.svh"

module ntt_post_process (
  input  logic                       clk,
  input  logic                       rst_n,
  // accept of the beat at the stage input, 3 cycles ahead of in_data
  input  logic                       accept,
  input  ntt_arith_pkg::bfly_word_t  in_data,
  input  ntt_ctrl_pkg::stream_ctrl_t in_ctrl,
  input  ntt_arith_pkg::bsk_word_t   bsk,
  input  logic                       bsk_vld,
  output ntt_arith_pkg::pp_word_t    out_data,
  output ntt_ctrl_pkg::stream_ctrl_t out_ctrl,
  output logic                       bsk_miss
);

  // factor alignment, depth matches clbu latency
  ntt_arith_pkg::bsk_word_t   bsk_q [3];
  // raw products, reduced in stage 2
  logic [`NTT_PSI-1:0][`NTT_R-1:0][`NTT_K_P1-1:0][2*`NTT_OP_W-1:0] s1_prod;
  ntt_ctrl_pkg::stream_ctrl_t s1_ctrl;

  // ==============================
  // key factor alignment
  // ==============================
  always_ff @(posedge clk) begin
    if (accept) begin
      bsk_q[0] <= bsk;
    end
    bsk_q[1] <= bsk_q[0];
    bsk_q[2] <= bsk_q[1];
  end

  // ==============================
  // matrix multiply
  // ==============================
  always_ff @(posedge clk) begin
    for (int i = 0; i < `NTT_PSI; i++) begin
      for (int j = 0; j < `NTT_R; j++) begin
        for (int k = 0; k < `NTT_K_P1; k++) begin
          s1_prod[i][j][k] <= (2*`NTT_OP_W)'(in_data[i][j])
                              * (2*`NTT_OP_W)'(bsk_q[2][i][j][k]);
          out_data[i][j][k] <= ntt_arith_pkg::mod_red(s1_prod[i][j][k]);
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_ctrl  <= '0;
      out_ctrl <= '0;
    end else begin
      s1_ctrl  <= in_ctrl;
      out_ctrl <= s1_ctrl;
    end
  end

  // factors checked at capture, not at use
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bsk_miss <= 1'b0;
    end else if (accept && !bsk_vld) begin
      bsk_miss <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/ntt_fwd_stage.sv */
/* NTT forward middle stage with matrix multiplication
   batch framing, butterfly cluster and key factor post process */

`timescale 1ns/100ps
`default_nettype none

module ntt_fwd_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  // input stream
  input  ntt_arith_pkg::bfly_word_t  in_data,
  input  ntt_ctrl_pkg::stream_ctrl_t in_ctrl,
  // twiddles and key factors, alongside the beat
  input  ntt_arith_pkg::twd_word_t   twd,
  input  logic                       twd_vld,
  input  ntt_arith_pkg::bsk_word_t   bsk,
  input  logic                       bsk_vld,
  // output stream, 5 cycles after the input edge
  output ntt_arith_pkg::pp_word_t    out_data,
  output ntt_ctrl_pkg::stream_ctrl_t out_ctrl,
  output ntt_ctrl_pkg::ntt_error_t   ntt_error
);

  logic                       accept;
  logic                       last_beat;
  logic                       framing_err;
  logic                       twd_miss;
  logic                       bsk_miss;
  // clbu to post process
  ntt_arith_pkg::bfly_word_t  clbu_data;
  ntt_ctrl_pkg::stream_ctrl_t clbu_ctrl;

  assign ntt_error = '{twd_miss: twd_miss, bsk_miss: bsk_miss, framing: framing_err};

  // ==============================
  // framing
  // ==============================
  ntt_batch_fsm ntt_batch_fsm_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_ctrl     (in_ctrl),
    .last_beat   (last_beat),
    .accept      (accept),
    .framing_err (framing_err)
  );

  ntt_beat_counter ntt_beat_counter_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .accept    (accept),
    .eob       (in_ctrl.eob),
    .last_beat (last_beat)
  );

  // ==============================
  // data pipeline
  // ==============================
  ntt_clbu ntt_clbu_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .accept   (accept),
    .in_data  (in_data),
    .in_ctrl  (in_ctrl),
    .twd      (twd),
    .twd_vld  (twd_vld),
    .out_data (clbu_data),
    .out_ctrl (clbu_ctrl),
    .twd_miss (twd_miss)
  );

  // factors enter with the input beat, aligned inside
  ntt_post_process ntt_post_process_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .accept   (accept),
    .in_data  (clbu_data),
    .in_ctrl  (clbu_ctrl),
    .bsk      (bsk),
    .bsk_vld  (bsk_vld),
    .out_data (out_data),
    .out_ctrl (out_ctrl),
    .bsk_miss (bsk_miss)
  );

endmodule

`default_nettype wire

/* bench/tb_ntt_fwd_stage.sv */
/* testbench for the NTT forward stage
   replays the pattern file, checks data, latency, framing and error bits */

`timescale 1ns/100ps
`default_nettype none

`include "ntt_defines.svh"

module tb_ntt_fwd_stage;

  localparam int CLK_PERIOD = 20;
  localparam int N_PAT      = 20;
  // 32-bit words per pattern line
  localparam int PAT_WORDS  = 25;
  // rising edges from input edge to output
  localparam int LATENCY    = 5;

  logic                       clk;
  logic                       rst_n;
  ntt_arith_pkg::bfly_word_t  in_data;
  ntt_ctrl_pkg::stream_ctrl_t in_ctrl;
  ntt_arith_pkg::twd_word_t   twd;
  logic                       twd_vld;
  ntt_arith_pkg::bsk_word_t   bsk;
  logic                       bsk_vld;
  ntt_arith_pkg::pp_word_t    out_data;
  ntt_ctrl_pkg::stream_ctrl_t out_ctrl;
  ntt_ctrl_pkg::ntt_error_t   ntt_error;

  logic [31:0] pat_mem [0:N_PAT*PAT_WORDS-1];
  // framing model verdict per line
  logic        acc_exp [N_PAT];
  // one line index per cycle in flight, -1 for idle
  int          exp_q [$];

  ntt_fwd_stage ntt_fwd_stage_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (in_data),
    .in_ctrl   (in_ctrl),
    .twd       (twd),
    .twd_vld   (twd_vld),
    .bsk       (bsk),
    .bsk_vld   (bsk_vld),
    .out_data  (out_data),
    .out_ctrl  (out_ctrl),
    .ntt_error (ntt_error)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // ==============================
  // pattern decode
  // ==============================
  function automatic string test_name(input int idx);
    if (idx < 8) return "bfly_keymul";
    else if (idx < 11) return "out_of_frame";
    else if (idx < 15) return "missing_factor";
    else return "length_check";
  endfunction

  // flag nibbles: avail sob eob pbs_id
  function automatic ntt_ctrl_pkg::stream_ctrl_t line_ctrl(input int idx);
    logic [31:0]                w;
    ntt_ctrl_pkg::stream_ctrl_t c;
    w        = pat_mem[idx*PAT_WORDS];
    c.avail  = w[12];
    c.sob    = w[8];
    c.eob    = w[4];
    c.pbs_id = w[3:0];
    return c;
  endfunction

  function automatic ntt_arith_pkg::pp_word_t line_out(input int idx);
    ntt_arith_pkg::pp_word_t p;
    for (int i = 0; i < `NTT_PSI; i++)
      for (int j = 0; j < `NTT_R; j++)
        for (int k = 0; k < `NTT_K_P1; k++)
          p[i][j][k] = pat_mem[idx*PAT_WORDS + 17 + 4*i + 2*j + k];
    return p;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic drive_idle();
    in_ctrl = '0;
    in_data = '0;
    twd     = '0;
    twd_vld = 1'b0;
    bsk     = '0;
    bsk_vld = 1'b0;
  endtask

  task automatic drive_line(input int idx);
    int b;
    b       = idx * PAT_WORDS;
    in_ctrl = line_ctrl(idx);
    twd_vld = pat_mem[b+1][4];
    bsk_vld = pat_mem[b+1][0];
    for (int i = 0; i < `NTT_PSI; i++) begin
      twd[i] = pat_mem[b + 7 + i];
      for (int j = 0; j < `NTT_R; j++) begin
        in_data[i][j] = pat_mem[b + 3 + 2*i + j];
        for (int k = 0; k < `NTT_K_P1; k++)
          bsk[i][j][k] = pat_mem[b + 9 + 4*i + 2*j + k];
      end
    end
  endtask

  // ==============================
  // output and error checks
  // ==============================
  task automatic check_cycle(input ntt_ctrl_pkg::ntt_error_t err_exp, input string err_test);
    int                         k;
    ntt_ctrl_pkg::stream_ctrl_t ctrl_exp;
    assert (ntt_error == err_exp) else
      fail_run($sformatf("FAIL %s error word: expected %h, actual %h",
                         err_test, err_exp, ntt_error));
    // nothing due out until the pipe has filled
    k = -1;
    if (exp_q.size() == LATENCY) begin
      k = exp_q.pop_front();
    end
    if (k < 0) begin
      assert (!out_ctrl.avail) else
        fail_run($sformatf("FAIL %s idle avail: expected 0, actual %b",
                           err_test, out_ctrl.avail));
    end else begin
      ctrl_exp       = line_ctrl(k);
      ctrl_exp.avail = acc_exp[k];
      // dropped beats must stay invisible
      assert (out_ctrl.avail == ctrl_exp.avail) else
        fail_run($sformatf("FAIL %s line %0d avail: expected %b, actual %b",
                           test_name(k), k, ctrl_exp.avail, out_ctrl.avail));
      if (ctrl_exp.avail) begin
        assert (out_ctrl == ctrl_exp) else
          fail_run($sformatf("FAIL %s line %0d ctrl: expected %h, actual %h",
                             test_name(k), k, ctrl_exp, out_ctrl));
        assert (out_data == line_out(k)) else
          fail_run($sformatf("FAIL %s line %0d data: expected %h, actual %h",
                             test_name(k), k, line_out(k), out_data));
      end
    end
  endtask

  // watchdog, pattern count plus slack
  initial begin
    #((N_PAT + 20) * CLK_PERIOD);
    fail_run($sformatf("timeout: run did not finish within %0d ns",
                       (N_PAT + 20) * CLK_PERIOD));
  end

  // ==============================
  // main sequence
  // ==============================
  initial begin
    ntt_ctrl_pkg::stream_ctrl_t c;
    ntt_ctrl_pkg::ntt_error_t   err_exp;
    string                      err_test;
    logic                       in_frame;
    clk      = 1'b0;
    rst_n    = 1'b0;
    drive_idle();
    in_frame = 1'b0;
    err_exp  = '0;
    err_test = "reset";
    $readmemh("bench/ntt_fwd_patterns.mem", pat_mem);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // outputs checked mid-cycle, inputs changed right after
    for (int n = 0; n < N_PAT + LATENCY; n++) begin
      check_cycle(err_exp, err_test);
      if (n < N_PAT) begin
        c = line_ctrl(n);
        // taken inside a frame or when it opens one
        acc_exp[n] = c.avail && (in_frame || c.sob);
        if (acc_exp[n]) begin
          in_frame = !c.eob;
        end
        drive_line(n);
        exp_q.push_back(n);
        err_exp  = ntt_ctrl_pkg::ntt_error_t'(pat_mem[n*PAT_WORDS + 2][2:0]);
        err_test = test_name(n);
      end else begin
        drive_idle();
        exp_q.push_back(-1);
      end
      @(negedge clk);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/ntt_fwd_patterns.mem */
// flags(avail sob eob pbs_id nibbles) vld(twd bsk) err(twd bsk framing) a0 b0 a1 b1 w0 w1
// then bsk[i][j][k] x8 and expected out[i][j][k] x8, all hex
1101 11 0  a 3 14 5  2 3  1 2 3 4 5 6 7 8  10 20 c 10 af d2 23 28
1001 11 0  1 1 100 10  2 10  1 1 1 fffde000 2 3 9 9  3 3 fffde000 1 400 600 0 0
1001 11 0  fffde000 1 7 0  1 5  5 6 2 1 3 4 10 1  0 0 fffddffd fffddfff 15 1c 70 7
1011 11 0  2 2 30 4  2 4  1 2 1 fffde000 4 1 2 3  6 c fffddfff 2 100 40 40 60
1102 11 0  1 1 3 1  1 1  1 2 3 4 5 6 7 8  2 4 0 0 14 18 e 10
1002 11 0  5 2 6 1  2 3  1 1 1 1 1 1 1 1  9 9 1 1 9 9 3 3
1002 11 0  8 1 9 0  4 7  2 2 2 2 2 2 2 2  18 18 8 8 12 12 12 12
1012 11 0  0 0 a 2  0 5  3 3 3 3 3 3 3 3  0 0 0 0 3c 3c 0 0
1003 11 0  55 1 0 0  1 0  1 1 1 1 1 1 1 1  0 0 0 0 0 0 0 0
1013 11 0  66 1 0 0  1 0  1 1 1 1 1 1 1 1  0 0 0 0 0 0 0 0
0103 11 0  77 1 0 0  1 0  1 1 1 1 1 1 1 1  0 0 0 0 0 0 0 0
1104 01 4  1 1 1 1  1 1  1 1 1 1 1 1 1 1  2 2 0 0 2 2 0 0
1004 11 4  2 1 4 2  1 1  1 1 1 1 1 1 1 1  3 3 1 1 6 6 2 2
1004 10 6  3 1 0 0  1 0  1 1 1 1 1 1 1 1  4 4 2 2 0 0 0 0
1014 11 6  1 0 0 0  0 0  1 1 1 1 1 1 1 1  1 1 1 1 0 0 0 0
1105 11 6  2 0 0 0  0 0  1 1 1 1 1 1 1 1  2 2 2 2 0 0 0 0
1005 11 6  0 3 0 0  1 0  1 1 1 1 1 1 1 1  3 3 fffddffe fffddffe 0 0 0 0
1015 11 7  4 0 0 0  0 0  1 1 1 1 1 1 1 1  4 4 4 4 0 0 0 0
1116 11 7  1 1 0 0  1 0  1 1 1 1 1 1 1 1  2 2 0 0 0 0 0 0
0000 11 7  0 0 0 0  0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0

/* vlog.f */
+incdir+include
design/ntt_arith_pkg.sv
design/ntt_ctrl_pkg.sv
design/ntt_batch_fsm.sv
design/ntt_beat_counter.sv
design/ntt_clbu.sv
design/ntt_post_process.sv
design/ntt_fwd_stage.sv
bench/tb_ntt_fwd_stage.sv

/* run_verilator.sh */
#!/bin/sh
# build and run the NTT forward stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_ntt_fwd_stage -f vlog.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "PASS: all tests"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
